//--- flist.f
hdl/texcache_pkg.sv
hdl/ring_bus_node.sv
hdl/block_addr_calc.sv
hdl/texcache_dma.sv
hdl/texcache_unit.sv
hdl/texcache_l2.sv
tests/tb_texcache_l2.sv

//--- hdl/block_addr_calc.sv
// ------------------------------
// block address calculator
// block coords to burst address,
// two registered stages
// ------------------------------

module block_addr_calc import texcache_pkg::*; #(
	parameter int BLK_SIZE = 1
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [MEM_ADDR_WIDTH-1:0] param_base,
	input  logic [MEM_ADDR_WIDTH-1:0] param_stride,
	input  ring_req_t                 s_req,
	input  logic                      s_valid,
	output logic                      s_ready,
	output mem_ar_t                   m_ar,
	output logic [ID_WIDTH-1:0]       m_id,
	output logic                      m_valid,
	input  logic                      m_ready
);

	localparam int BLK_WORDS = 1 << (2 * BLK_SIZE);

	logic                      advance;
	logic                      st1_valid;
	logic [MEM_ADDR_WIDTH-1:0] st1_ofs;
	logic [ID_WIDTH-1:0]       st1_id;

	// whole pipe stalls together
	assign advance = !m_valid || m_ready;
	assign s_ready = advance;

	always_ff @(posedge clk) begin
		if (reset) begin
			st1_valid <= 1'b0;
			m_valid   <= 1'b0;
		end else if (advance) begin
			st1_valid <= s_valid;
			m_valid   <= st1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			st1_ofs <= MEM_ADDR_WIDTH'(s_req.by) * param_stride
				+ (MEM_ADDR_WIDTH'(s_req.bx) << (2 * BLK_SIZE));
			st1_id     <= s_req.src;
			m_ar.addr  <= param_base + st1_ofs;
			m_ar.len   <= LEN_WIDTH'(BLK_WORDS - 1);
			m_id       <= st1_id;
		end
	end

endmodule

//--- hdl/ring_bus_node.sv
// ------------------------------
// ring bus node
// one registered slot of a valid-only
// ring, captures addressed slots and
// injects into empty ones
// ------------------------------

module ring_bus_node import texcache_pkg::*; #(
	parameter type slot_t = logic [ID_WIDTH:0],
	parameter int  NODE_ID = 0,
	parameter bit  ANY_DST = 1'b0
) (
	input  logic  clk,
	input  logic  reset,
	input  slot_t src_slot,
	input  logic  src_valid,
	output slot_t sink_slot,
	output logic  sink_valid,
	input  slot_t inj_slot,
	input  logic  inj_valid,
	output logic  inj_ready,
	output slot_t cap_slot,
	output logic  cap_valid,
	input  logic  cap_ready
);

	localparam int SLOT_WIDTH = $bits(slot_t);

	logic [SLOT_WIDTH-1:0] src_bits;
	logic [ID_WIDTH-1:0]   dst;
	logic                  capture;

	// destination id sits in the top bits of the slot
	assign src_bits = src_slot;
	assign dst      = src_bits[SLOT_WIDTH-1 -: ID_WIDTH];

	assign cap_slot  = src_slot;
	assign cap_valid = src_valid && (ANY_DST || dst == ID_WIDTH'(NODE_ID));
	assign capture   = cap_valid && cap_ready;
	assign inj_ready = !src_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			sink_valid <= 1'b0;
		end else begin
			sink_valid <= (src_valid && !capture) || (!src_valid && inj_valid);
		end
	end

	always_ff @(posedge clk) begin
		sink_slot <= src_valid ? src_slot : inj_slot;
	end

	// local item waits unchanged for an empty slot
	a_inj_held: assert property (@(posedge clk) disable iff (reset)
		(inj_valid && !inj_ready) |=> (inj_valid && $stable(inj_slot)));

endmodule

//--- hdl/texcache_dma.sv
// ------------------------------
// refill DMA
// one burst read at a time, beats go
// out tagged with requester id
// ------------------------------

module texcache_dma import texcache_pkg::*; #(
	parameter int BLK_SIZE = 1
) (
	input  logic                  clk,
	input  logic                  reset,
	input  mem_ar_t               s_ar,
	input  logic [ID_WIDTH-1:0]   s_id,
	input  logic                  s_valid,
	output logic                  s_ready,
	output mem_ar_t               mem_ar,
	output logic                  mem_arvalid,
	input  logic                  mem_arready,
	input  logic [DATA_WIDTH-1:0] mem_rdata,
	input  logic                  mem_rlast,
	input  logic                  mem_rvalid,
	output logic                  mem_rready,
	output ring_resp_t            m_resp,
	output logic                  m_valid,
	input  logic                  m_ready
);

	localparam int BLK_WORDS = 1 << (2 * BLK_SIZE);

	dma_state_e           state;
	logic [LEN_WIDTH-1:0] beat_cnt;
	logic [ID_WIDTH-1:0]  req_id;
	logic                 beat_fire;
	logic                 final_beat;

	assign s_ready     = (state == DMA_IDLE);
	assign mem_arvalid = (state == DMA_ADDR);
	// hold off memory while a word still waits for a ring slot
	assign mem_rready  = (state == DMA_BURST) && (!m_valid || m_ready);
	assign beat_fire   = mem_rvalid && mem_rready;
	assign final_beat  = (beat_cnt == LEN_WIDTH'(BLK_WORDS - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= DMA_IDLE;
			m_valid  <= 1'b0;
			beat_cnt <= '0;
		end else begin
			if (beat_fire) begin
				m_valid <= 1'b1;
			end else if (m_ready) begin
				m_valid <= 1'b0;
			end
			case (state)
				DMA_IDLE: begin
					if (s_valid) begin
						state <= DMA_ADDR;
					end
				end
				DMA_ADDR: begin
					if (mem_arready) begin
						state    <= DMA_BURST;
						beat_cnt <= '0;
					end
				end
				DMA_BURST: begin
					if (beat_fire) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (final_beat) begin
							state <= DMA_DRAIN;
						end
					end
				end
				default: begin
					if (!m_valid || m_ready) begin
						state <= DMA_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (s_valid && s_ready) begin
			mem_ar <= s_ar;
			req_id <= s_id;
		end
		if (beat_fire) begin
			m_resp <= '{dst: req_id, last: mem_rlast, data: mem_rdata};
		end
	end

	a_rlast_on_count: assert property (@(posedge clk) disable iff (reset)
		beat_fire |-> (mem_rlast == final_beat));

endmodule

//--- hdl/texcache_l2.sv
// ------------------------------
// shared texture cache top
// per-client units, request and
// response rings, address calc, DMA
// ------------------------------

module texcache_l2 import texcache_pkg::*; #(
	parameter int S_NUM          = 2,
	parameter int BLK_SIZE       = 1,
	parameter int TAG_ADDR_WIDTH = 2
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [MEM_ADDR_WIDTH-1:0] param_base,
	input  logic [MEM_ADDR_WIDTH-1:0] param_stride,
	input  logic                      clear_start,
	output logic                      clear_busy,
	input  tex_req_t  [S_NUM-1:0]     s_ar,
	input  logic      [S_NUM-1:0]     s_arvalid,
	output logic      [S_NUM-1:0]     s_arready,
	output tex_resp_t [S_NUM-1:0]     s_r,
	output logic      [S_NUM-1:0]     s_rvalid,
	input  logic      [S_NUM-1:0]     s_rready,
	output mem_ar_t                   mem_ar,
	output logic                      mem_arvalid,
	input  logic                      mem_arready,
	input  logic [DATA_WIDTH-1:0]     mem_rdata,
	input  logic                      mem_rlast,
	input  logic                      mem_rvalid,
	output logic                      mem_rready
);

	// node 0 is the DMA, node i+1 is unit i
	ring_req_t  [S_NUM:0] req_ring;
	ring_req_t  [S_NUM:0] req_inj;
	ring_req_t  [S_NUM:0] req_cap;
	logic       [S_NUM:0] req_ring_valid;
	logic       [S_NUM:0] req_inj_valid;
	logic       [S_NUM:0] req_inj_ready;
	logic       [S_NUM:0] req_cap_valid;
	logic       [S_NUM:0] req_cap_ready;
	ring_resp_t [S_NUM:0] resp_ring;
	ring_resp_t [S_NUM:0] resp_inj;
	ring_resp_t [S_NUM:0] resp_cap;
	logic       [S_NUM:0] resp_ring_valid;
	logic       [S_NUM:0] resp_inj_valid;
	logic       [S_NUM:0] resp_inj_ready;
	logic       [S_NUM:0] resp_cap_valid;
	logic       [S_NUM:0] resp_cap_ready;
	logic [S_NUM-1:0]     unit_busy;

	mem_ar_t             calc_ar;
	logic [ID_WIDTH-1:0] calc_id;
	logic                calc_valid;
	logic                calc_ready;

	assign clear_busy = |unit_busy;

	// ------------------------------
	// rings
	// ------------------------------
	for (genvar k = 0; k <= S_NUM; k++) begin : g_node
		ring_bus_node #(
			.slot_t  (ring_req_t),
			.NODE_ID (k),
			.ANY_DST (k == 0)
		) req_node_inst (
			.clk        (clk),
			.reset      (reset),
			.src_slot   (req_ring[(k + S_NUM) % (S_NUM + 1)]),
			.src_valid  (req_ring_valid[(k + S_NUM) % (S_NUM + 1)]),
			.sink_slot  (req_ring[k]),
			.sink_valid (req_ring_valid[k]),
			.inj_slot   (req_inj[k]),
			.inj_valid  (req_inj_valid[k]),
			.inj_ready  (req_inj_ready[k]),
			.cap_slot   (req_cap[k]),
			.cap_valid  (req_cap_valid[k]),
			.cap_ready  (req_cap_ready[k])
		);

		ring_bus_node #(
			.slot_t  (ring_resp_t),
			.NODE_ID (k),
			.ANY_DST (1'b0)
		) resp_node_inst (
			.clk        (clk),
			.reset      (reset),
			.src_slot   (resp_ring[(k + S_NUM) % (S_NUM + 1)]),
			.src_valid  (resp_ring_valid[(k + S_NUM) % (S_NUM + 1)]),
			.sink_slot  (resp_ring[k]),
			.sink_valid (resp_ring_valid[k]),
			.inj_slot   (resp_inj[k]),
			.inj_valid  (resp_inj_valid[k]),
			.inj_ready  (resp_inj_ready[k]),
			.cap_slot   (resp_cap[k]),
			.cap_valid  (resp_cap_valid[k]),
			.cap_ready  (resp_cap_ready[k])
		);
	end

	// ------------------------------
	// client units
	// ------------------------------
	for (genvar i = 0; i < S_NUM; i++) begin : g_unit
		assign req_cap_ready[i+1]  = 1'b0;
		assign resp_inj[i+1]       = '0;
		assign resp_inj_valid[i+1] = 1'b0;
		assign resp_cap_ready[i+1] = 1'b1;

		texcache_unit #(
			.BLK_SIZE       (BLK_SIZE),
			.TAG_ADDR_WIDTH (TAG_ADDR_WIDTH),
			.NODE_ID        (i + 1)
		) unit_inst (
			.clk         (clk),
			.reset       (reset),
			.clear_start (clear_start),
			.clear_busy  (unit_busy[i]),
			.s_ar        (s_ar[i]),
			.s_arvalid   (s_arvalid[i]),
			.s_arready   (s_arready[i]),
			.s_r         (s_r[i]),
			.s_rvalid    (s_rvalid[i]),
			.s_rready    (s_rready[i]),
			.m_req       (req_inj[i+1]),
			.m_reqvalid  (req_inj_valid[i+1]),
			.m_reqready  (req_inj_ready[i+1]),
			.m_resp      (resp_cap[i+1]),
			.m_respvalid (resp_cap_valid[i+1])
		);
	end

	// ------------------------------
	// DMA side
	// ------------------------------
	assign req_inj[0]        = '0;
	assign req_inj_valid[0]  = 1'b0;
	assign resp_cap_ready[0] = 1'b0;

	block_addr_calc #(
		.BLK_SIZE (BLK_SIZE)
	) calc_inst (
		.clk          (clk),
		.reset        (reset),
		.param_base   (param_base),
		.param_stride (param_stride),
		.s_req        (req_cap[0]),
		.s_valid      (req_cap_valid[0]),
		.s_ready      (req_cap_ready[0]),
		.m_ar         (calc_ar),
		.m_id         (calc_id),
		.m_valid      (calc_valid),
		.m_ready      (calc_ready)
	);

	texcache_dma #(
		.BLK_SIZE (BLK_SIZE)
	) dma_inst (
		.clk         (clk),
		.reset       (reset),
		.s_ar        (calc_ar),
		.s_id        (calc_id),
		.s_valid     (calc_valid),
		.s_ready     (calc_ready),
		.mem_ar      (mem_ar),
		.mem_arvalid (mem_arvalid),
		.mem_arready (mem_arready),
		.mem_rdata   (mem_rdata),
		.mem_rlast   (mem_rlast),
		.mem_rvalid  (mem_rvalid),
		.mem_rready  (mem_rready),
		.m_resp      (resp_inj[0]),
		.m_valid     (resp_inj_valid[0]),
		.m_ready     (resp_inj_ready[0])
	);

endmodule

//--- hdl/texcache_pkg.sv
// ------------------------------
// texture cache shared types
// widths, bus structs and state
// encodings for units, rings and DMA
// ------------------------------

package texcache_pkg;

	localparam int COORD_WIDTH    = 8;
	localparam int DATA_WIDTH     = 16;
	localparam int MEM_ADDR_WIDTH = 20;
	localparam int ID_WIDTH       = 2;
	localparam int USER_WIDTH     = 4;
	localparam int LEN_WIDTH      = 8;

	// client side
	typedef struct packed {
		logic [USER_WIDTH-1:0]  user;
		logic [COORD_WIDTH-1:0] x;
		logic [COORD_WIDTH-1:0] y;
	} tex_req_t;

	typedef struct packed {
		logic [USER_WIDTH-1:0] user;
		logic [DATA_WIDTH-1:0] data;
	} tex_resp_t;

	// ring slots
	typedef struct packed {
		logic [ID_WIDTH-1:0]    src;
		logic [COORD_WIDTH-1:0] bx;
		logic [COORD_WIDTH-1:0] by;
	} ring_req_t;

	// dst must stay the top field, ring nodes match on it
	typedef struct packed {
		logic [ID_WIDTH-1:0]   dst;
		logic                  last;
		logic [DATA_WIDTH-1:0] data;
	} ring_resp_t;

	typedef struct packed {
		logic [MEM_ADDR_WIDTH-1:0] addr;
		logic [LEN_WIDTH-1:0]      len;
	} mem_ar_t;

	typedef enum logic [1:0] {UNIT_IDLE, UNIT_REQ, UNIT_FILL, UNIT_CLEAR} unit_state_e;

	typedef enum logic [1:0] {DMA_IDLE, DMA_ADDR, DMA_BURST, DMA_DRAIN} dma_state_e;

endpackage

//--- hdl/texcache_unit.sv
// ------------------------------
// texture cache unit
// direct-mapped block cache for one
// client with miss refill and clear
// ------------------------------

module texcache_unit import texcache_pkg::*; #(
	parameter int BLK_SIZE       = 1,
	parameter int TAG_ADDR_WIDTH = 2,
	parameter int NODE_ID        = 1
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       clear_start,
	output logic       clear_busy,
	input  tex_req_t   s_ar,
	input  logic       s_arvalid,
	output logic       s_arready,
	output tex_resp_t  s_r,
	output logic       s_rvalid,
	input  logic       s_rready,
	output ring_req_t  m_req,
	output logic       m_reqvalid,
	input  logic       m_reqready,
	input  ring_resp_t m_resp,
	input  logic       m_respvalid
);

	localparam int LINES     = 1 << TAG_ADDR_WIDTH;
	localparam int OFS_WIDTH = 2 * BLK_SIZE;
	localparam int MEM_WIDTH = TAG_ADDR_WIDTH + OFS_WIDTH;

	unit_state_e               state;
	logic [LINES-1:0]          tag_valid;
	logic [2*COORD_WIDTH-1:0]  tag_mem [LINES];
	logic [DATA_WIDTH-1:0]     blk_mem [1 << MEM_WIDTH];

	tex_req_t                  st0_req;
	logic                      st0_valid;
	logic [COORD_WIDTH-1:0]    st0_bx;
	logic [COORD_WIDTH-1:0]    st0_by;
	logic [TAG_ADDR_WIDTH-1:0] st0_idx;
	logic [MEM_WIDTH-1:0]      st0_addr;
	logic                      st0_hit;
	logic                      st0_fire;
	logic                      advance;
	logic                      fill_word;
	logic [OFS_WIDTH-1:0]      fill_cnt;
	logic [TAG_ADDR_WIDTH-1:0] clr_cnt;

	// ------------------------------
	// tag stage
	// ------------------------------
	assign st0_bx   = st0_req.x >> BLK_SIZE;
	assign st0_by   = st0_req.y >> BLK_SIZE;
	assign st0_idx  = st0_bx[TAG_ADDR_WIDTH-1:0];
	assign st0_addr = {st0_idx, st0_req.y[BLK_SIZE-1:0], st0_req.x[BLK_SIZE-1:0]};
	assign st0_hit  = tag_valid[st0_idx] && (tag_mem[st0_idx] == {st0_bx, st0_by});

	// low s_rready freezes both stages
	assign advance   = !s_rvalid || s_rready;
	assign st0_fire  = (state == UNIT_IDLE) && advance && st0_valid && st0_hit;
	assign s_arready = (state == UNIT_IDLE) && advance && (!st0_valid || st0_hit);
	assign fill_word = (state == UNIT_FILL) && m_respvalid;

	assign m_req      = '{src: ID_WIDTH'(NODE_ID), bx: st0_bx, by: st0_by};
	assign m_reqvalid = (state == UNIT_REQ);
	assign clear_busy = (state == UNIT_CLEAR);

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= UNIT_IDLE;
			tag_valid <= '0;
			st0_valid <= 1'b0;
			s_rvalid  <= 1'b0;
			fill_cnt  <= '0;
			clr_cnt   <= '0;
		end else begin
			case (state)
				UNIT_IDLE: begin
					if (clear_start) begin
						state   <= UNIT_CLEAR;
						clr_cnt <= '0;
					end else if (st0_valid && !st0_hit) begin
						state <= UNIT_REQ;
					end
				end
				UNIT_REQ: begin
					if (m_reqready) begin
						state    <= UNIT_FILL;
						fill_cnt <= '0;
					end
				end
				UNIT_FILL: begin
					if (m_respvalid) begin
						fill_cnt <= fill_cnt + 1'b1;
						// back to idle, stalled request then hits
						if (m_resp.last) begin
							tag_valid[st0_idx] <= 1'b1;
							state              <= UNIT_IDLE;
						end
					end
				end
				default: begin
					tag_valid[clr_cnt] <= 1'b0;
					clr_cnt            <= clr_cnt + 1'b1;
					if (clr_cnt == '1) begin
						state <= UNIT_IDLE;
					end
				end
			endcase
			if (s_arvalid && s_arready) begin
				st0_valid <= 1'b1;
			end else if (st0_fire) begin
				st0_valid <= 1'b0;
			end
			if (advance) begin
				s_rvalid <= st0_fire;
			end
		end
	end

	// ------------------------------
	// request, memories and data stage
	// ------------------------------
	always_ff @(posedge clk) begin
		if (s_arvalid && s_arready) begin
			st0_req <= s_ar;
		end
		if (fill_word) begin
			blk_mem[{st0_idx, fill_cnt}] <= m_resp.data;
		end
		if (fill_word && m_resp.last) begin
			tag_mem[st0_idx] <= {st0_bx, st0_by};
		end
		if (st0_fire) begin
			s_r.user <= st0_req.user;
			s_r.data <= blk_mem[st0_addr];
		end
	end

	a_r_stable: assert property (@(posedge clk) disable iff (reset)
		(s_rvalid && !s_rready) |=> (s_rvalid && $stable(s_r)));

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the texture cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f flist.f \
	--top-module tb_texcache_l2 -Mdir obj_dir; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_texcache_l2)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
	exit 0
fi
exit 1

//--- tests/tb_texcache_l2.sv
// ------------------------------
// texture cache testbench
// pattern driven reads and clears
// against a burst memory model
// ------------------------------

module tb_texcache_l2 import texcache_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLIENTS = 2;

	logic                      clk;
	logic                      reset;
	logic [MEM_ADDR_WIDTH-1:0] param_base;
	logic [MEM_ADDR_WIDTH-1:0] param_stride;
	logic                      clear_start;
	logic                      clear_busy;
	tex_req_t  [CLIENTS-1:0]   s_ar;
	logic      [CLIENTS-1:0]   s_arvalid;
	logic      [CLIENTS-1:0]   s_arready;
	tex_resp_t [CLIENTS-1:0]   s_r;
	logic      [CLIENTS-1:0]   s_rvalid;
	logic      [CLIENTS-1:0]   s_rready;
	mem_ar_t                   mem_ar;
	logic                      mem_arvalid;
	logic                      mem_arready;
	logic [DATA_WIDTH-1:0]     mem_rdata;
	logic                      mem_rlast;
	logic                      mem_rvalid;
	logic                      mem_rready;

	// queue item is {hit, expected data, request}
	logic [36:0]             req_q [CLIENTS][$];
	logic [36:0]             exp_q [CLIENTS][$];
	int                      acc_q [CLIENTS][$];
	logic [CLIENTS-1:0]      ar_fire;
	logic [CLIENTS-1:0]      r_fire;
	tex_resp_t [CLIENTS-1:0] r_data;
	logic                    mem_ar_fire;
	logic                    mem_r_fire;
	logic                    mem_busy;
	logic [19:0]             mem_addr;
	logic [7:0]              mem_len;
	logic [7:0]              mem_beat;
	int                      mem_wait;
	logic                    toggle_rready;
	logic [15:0]             drv_lfsr;
	logic [15:0]             stim_lfsr;
	logic                    aborted;
	int                      cyc;
	int                      errors;
	int                      bursts;
	int                      test_mark;
	int                      burst_mark;
	int                      passed;
	int                      failed;

	texcache_l2 #(
		.S_NUM          (CLIENTS),
		.BLK_SIZE       (1),
		.TAG_ADDR_WIDTH (2)
	) texcache_l2_inst (
		.clk          (clk),
		.reset        (reset),
		.param_base   (param_base),
		.param_stride (param_stride),
		.clear_start  (clear_start),
		.clear_busy   (clear_busy),
		.s_ar         (s_ar),
		.s_arvalid    (s_arvalid),
		.s_arready    (s_arready),
		.s_r          (s_r),
		.s_rvalid     (s_rvalid),
		.s_rready     (s_rready),
		.mem_ar       (mem_ar),
		.mem_arvalid  (mem_arvalid),
		.mem_arready  (mem_arready),
		.mem_rdata    (mem_rdata),
		.mem_rlast    (mem_rlast),
		.mem_rvalid   (mem_rvalid),
		.mem_rready   (mem_rready)
	);

	always #20 clk = ~clk;

	// 16 bit fibonacci, taps 16 14 13 11
	function automatic logic lfsr_step(inout logic [15:0] st);
		logic fb;
		fb = st[15] ^ st[13] ^ st[12] ^ st[10];
		st = {st[14:0], fb};
		return fb;
	endfunction

	function automatic int rand_bits(inout logic [15:0] st, input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_step(st));
		end
		return v;
	endfunction

	// base 0x100, stride 32, 2x2 blocks
	function automatic logic [15:0] expected_texel(input logic [7:0] x, input logic [7:0] y);
		logic [19:0] a;
		a = 20'h100 + 20'(y >> 1) * 20'd32 + 20'(x >> 1) * 20'd4
			+ 20'(y[0]) * 20'd2 + 20'(x[0]);
		return a[15:0];
	endfunction

	function automatic logic queues_empty();
		logic e;
		e = 1'b1;
		for (int c = 0; c < CLIENTS; c++) begin
			if (req_q[c].size() != 0 || exp_q[c].size() != 0) begin
				e = 1'b0;
			end
		end
		return e;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("error %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// remaining waits fall through once this is set
	task automatic abort_run(input string why);
		$display("%s", why);
		aborted = 1'b1;
	endtask

	task automatic wait_drain(input int limit);
		int t;
		t = 0;
		while (!aborted && !queues_empty()) begin
			@(posedge clk);
			t++;
			if (t > limit) begin
				abort_run("reads did not complete in time");
			end
		end
		@(posedge clk);
	endtask

	task automatic finish_test(input int id);
		int n;
		n = errors - test_mark;
		if (n == 0) begin
			passed++;
		end else begin
			failed++;
		end
		$display("test %0d done with %0d errors", id, n);
		test_mark = errors;
		burst_mark = bursts;
	endtask

	task automatic run_clear();
		int busy_cnt;
		busy_cnt = 0;
		wait_drain(2000);
		if (!aborted) begin
			@(negedge clk);
			clear_start = 1'b1;
			@(negedge clk);
			clear_start = 1'b0;
			while (!aborted && clear_busy) begin
				check_value("s_arready during clear", 32'(s_arready), 32'd0);
				busy_cnt++;
				if (busy_cnt > 64) begin
					abort_run("clear_busy never dropped");
				end
				@(negedge clk);
			end
			check_value("clear busy cycles", 32'(busy_cnt), 32'd4);
			@(posedge clk);
		end
	endtask

	// ------------------------------
	// client handshakes, memory model
	// ------------------------------
	always @(negedge clk) begin
		logic [36:0] item;
		logic [19:0] word_addr;
		int          lat;
		cyc++;
		for (int c = 0; c < CLIENTS; c++) begin
			if (ar_fire[c]) begin
				item = req_q[c].pop_front();
				exp_q[c].push_back(item);
				acc_q[c].push_back(cyc);
			end
			if (r_fire[c]) begin
				item = exp_q[c].pop_front();
				lat = cyc - acc_q[c].pop_front();
				check_value("read answer", 32'(r_data[c]), 32'({item[19:16], item[35:20]}));
				if (item[36]) begin
					check_value("hit latency", 32'(lat), 32'd2);
				end
			end
		end
		if (mem_ar_fire) begin
			mem_busy = 1'b1;
			mem_addr = mem_ar.addr;
			mem_len  = mem_ar.len;
			mem_beat = '0;
			mem_wait = rand_bits(drv_lfsr, 2);
			bursts++;
			check_value("burst length", 32'(mem_ar.len), 32'd3);
		end else if (mem_r_fire) begin
			if (mem_beat == mem_len) begin
				mem_busy = 1'b0;
			end
			mem_beat = mem_beat + 8'd1;
			mem_wait = rand_bits(drv_lfsr, 2);
		end else if (mem_busy && mem_wait != 0) begin
			mem_wait--;
		end
		word_addr   = mem_addr + 20'(mem_beat);
		mem_arready = !mem_busy;
		mem_rvalid  = mem_busy && mem_wait == 0;
		mem_rdata   = word_addr[15:0];
		mem_rlast   = mem_beat == mem_len;
		for (int c = 0; c < CLIENTS; c++) begin
			s_arvalid[c] = req_q[c].size() != 0;
			if (s_arvalid[c]) begin
				s_ar[c] = req_q[c][0][19:0];
			end
			s_rready[c] = toggle_rready ? lfsr_step(drv_lfsr) : 1'b1;
		end
		#1;
		ar_fire     = s_arvalid & s_arready;
		r_fire      = s_rvalid & s_rready;
		r_data      = s_r;
		mem_ar_fire = mem_arvalid && mem_arready;
		mem_r_fire  = mem_rvalid && mem_rready;
	end

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		string       line;
		int          fd;
		int          n;
		int          row;
		int          test_id;
		int          cmd;
		int          client;
		logic [31:0] rx;
		logic [31:0] ry;
		logic [31:0] rval;
		tex_req_t    req;
		clk = 1'b0;
		reset = 1'b1;
		param_base = 20'h100;
		param_stride = 20'd32;
		clear_start = 1'b0;
		s_ar = '0;
		s_arvalid = '0;
		s_rready = '1;
		mem_arready = 1'b0;
		mem_rdata = '0;
		mem_rlast = 1'b0;
		mem_rvalid = 1'b0;
		ar_fire = '0;
		r_fire = '0;
		r_data = '0;
		mem_ar_fire = 1'b0;
		mem_r_fire = 1'b0;
		mem_busy = 1'b0;
		mem_addr = '0;
		mem_len = '0;
		mem_beat = '0;
		mem_wait = 0;
		toggle_rready = 1'b0;
		drv_lfsr = 16'd6;
		stim_lfsr = 16'd6;
		aborted = 1'b0;
		cyc = 0;
		errors = 0;
		bursts = 0;
		test_mark = 0;
		burst_mark = 0;
		passed = 0;
		failed = 0;
		row = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(posedge clk);
		fd = $fopen("tests/texcache_patterns.txt", "r");
		if (fd == 0) begin
			abort_run("could not open the pattern file");
		end else begin
			while (!aborted && $fgets(line, fd) != 0) begin
				n = $sscanf(line, "%d %d %d %h %h %h", test_id, cmd, client, rx, ry, rval);
				if (line.substr(0, 0) == "#" || n != 6) begin
					continue;
				end
				row++;
				case (cmd)
					0, 3: begin
						req = '{user: 4'(row), x: rx[7:0], y: ry[7:0]};
						req_q[client].push_back({cmd == 3, rval[15:0], req});
					end
					1: run_clear();
					default: begin
						wait_drain(2000);
						check_value("burst count", 32'(bursts - burst_mark), rval);
						finish_test(test_id);
					end
				endcase
			end
			$fclose(fd);
		end
		if (!aborted) begin
			// long random stretch with s_rready toggling
			toggle_rready = 1'b1;
			for (int k = 0; k < 48; k++) begin
				client = rand_bits(stim_lfsr, 1);
				rx = 32'(rand_bits(stim_lfsr, 4));
				ry = 32'(rand_bits(stim_lfsr, 4));
				req = '{user: 4'(k), x: rx[7:0], y: ry[7:0]};
				req_q[client].push_back({1'b0, expected_texel(rx[7:0], ry[7:0]), req});
			end
			wait_drain(20000);
			toggle_rready = 1'b0;
			finish_test(6);
		end
		$display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
		if (errors == 0 && !aborted) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- tests/texcache_patterns.txt
# columns: test cmd client x y value, with x, y and value in hex
# cmd 0 read, 3 read that must hit, 1 clear, 2 end of test (value is burst count)
# first read of a block
1 0 0 05 03 012b
1 2 0 00 00 1
# hit in the same block
2 3 0 04 02 0128
2 2 0 00 00 0
# two clients miss together
3 0 0 10 20 0320
3 0 1 0b 07 0177
3 2 0 00 00 2
# two blocks on one line
4 0 1 02 01 0106
4 0 1 0a 00 0114
4 0 1 03 00 0105
4 2 0 00 00 3
# clear, then the old hit misses
5 1 0 00 00 0
5 0 0 04 02 0128
5 2 0 00 00 1
